// File: files.f
+incdir+.
uart_dbg_pkg.sv
mem_port_if.sv
uart_rx.sv
uart_tx.sv
dbg_mem.sv
uart_dbg_engine.sv
uart_dbg_top.sv
tb_uart_dbg.sv

// File: Bender.yml
package:
  name: uart_dbg

sources:
  - files:
      - uart_dbg_pkg.sv
      - mem_port_if.sv
      - uart_rx.sv
      - uart_tx.sv
      - dbg_mem.sv
      - uart_dbg_engine.sv
      - uart_dbg_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_uart_dbg.sv

// File: tb_uart_tasks.svh
////////////////////////////////////////////////////////////
// Failure reporting and compares
////////////////////////////////////////////////////////////

task automatic report_fail(input string why);
  $display("%s", why);
  $display(">>> FAIL");
  $fatal(1);
endtask

task automatic check_byte(input string name, input dbg_byte_t got, input dbg_byte_t exp);
  if (got !== exp) begin
    report_fail($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
  end
endtask

task automatic check_word(input string name, input dbg_word_t got, input dbg_word_t exp);
  if (got !== exp) begin
    report_fail($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    report_fail($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
  end
endtask

////////////////////////////////////////////////////////////
// Stimulus bytes
////////////////////////////////////////////////////////////

// Taps 32, 22, 2, 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic rand_byte(output dbg_byte_t b);
  for (int i = 0; i < 8; i++) begin
    lfsr_q = lfsr_next(lfsr_q);
    b[i] = lfsr_q[0];
  end
endtask

////////////////////////////////////////////////////////////
// Serial line
////////////////////////////////////////////////////////////

// One start bit, eight data bits LSB first, one stop bit
task automatic send_byte(input dbg_byte_t b);
  logic [FrameBits-1:0] frame;
  frame = {1'b1, b, 1'b0};
  for (int i = 0; i < FrameBits; i++) begin
    @(posedge clk);
    uart_rx_i <= frame[i];
    repeat (ClksPerBit - 1) @(posedge clk);
  end
endtask

task automatic send_field(input logic [63:0] value);
  for (int i = 0; i < FieldBytes; i++) begin
    send_byte(value[8*i +: 8]);
  end
endtask

// Samples each bit at its centre, on falling clock edges
task automatic recv_byte(output dbg_byte_t b);
  @(negedge uart_tx_o);
  repeat (HalfBit) @(negedge clk);
  if (uart_tx_o !== 1'b0) begin
    report_fail("Start bit on uart_tx_o did not last to its centre");
  end
  for (int i = 0; i < 8; i++) begin
    repeat (ClksPerBit) @(negedge clk);
    b[i] = uart_tx_o;
  end
  repeat (ClksPerBit) @(negedge clk);
  if (uart_tx_o !== 1'b1) begin
    report_fail("Stop bit on uart_tx_o was low");
  end
endtask

// File: tb_uart_dbg.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart_dbg;
  import uart_dbg_pkg::*;

  typedef enum {OpChal, OpWrite, OpRead, OpExec, OpJunk} op_e;
  typedef enum {SrcNone, SrcLfsr, SrcShadow} src_e;

  // Junk entries send the low address byte
  typedef struct {
    op_e         op;
    logic [63:0] addr;
    int unsigned len;
    src_e        src;
  } entry_t;

  localparam int unsigned NumTests    = 10;
  localparam int unsigned ClkPeriodNs = 40;

  logic        clk = 1'b0;
  logic        rst_i = 1'b1;
  logic        uart_rx_i = 1'b1;
  logic        uart_tx_o;
  logic        exec_valid_o;
  dbg_word_t   exec_entry_o;

  logic [31:0]     lfsr_q = 32'h4e377046;
  dbg_byte_t       rx_q [$];
  dbg_byte_t       shadow [MemDepth];
  int unsigned     exec_count = 0;
  dbg_word_t       exec_seen;
  longint unsigned limit_ns;

  entry_t tests [NumTests] = '{
    '{OpChal,  64'h0,                   0, SrcNone},
    '{OpWrite, 64'h7f3c_0000_9a00_1237, 6, SrcLfsr},
    '{OpRead,  64'h7f3c_0000_9a00_1237, 6, SrcShadow},
    // Crosses the top of memory
    '{OpWrite, 64'h0000_0000_0000_00fc, 8, SrcLfsr},
    '{OpRead,  64'h1100_0000_0000_00fe, 5, SrcShadow},
    '{OpRead,  64'h0000_0000_0000_0039, 3, SrcShadow},
    '{OpExec,  64'hdead_beef_8000_1040, 0, SrcNone},
    '{OpJunk,  64'h55,                  0, SrcNone},
    '{OpChal,  64'h0,                   0, SrcNone},
    '{OpExec,  64'h0123_4567_89ab_cdef, 0, SrcNone}
  };

  `include "tb_uart_tasks.svh"

  always #20 clk = ~clk;

  uart_dbg_top dut_i (
    .clk          ( clk          ),
    .rst_i        ( rst_i        ),
    .uart_rx_i    ( uart_rx_i    ),
    .uart_tx_o    ( uart_tx_o    ),
    .exec_valid_o ( exec_valid_o ),
    .exec_entry_o ( exec_entry_o )
  );

  // Twenty bit periods with an idle line and no exec pulse
  task automatic quiet_window();
    repeat (2 * FrameBits * ClksPerBit) begin
      @(negedge clk);
      check_bit("uart_tx_o idle", uart_tx_o, 1'b1);
      check_bit("exec_valid_o", exec_valid_o, 1'b0);
    end
  endtask

  // Bytes on both lines plus the quiet window
  function automatic int unsigned entry_bytes(input entry_t e);
    int unsigned n;
    case (e.op)
      OpChal:  n = 2;
      OpJunk:  n = 1;
      OpExec:  n = FieldBytes + 2;
      default: n = 2 * FieldBytes + e.len + 3;
    endcase
    return n + 2;
  endfunction

  initial begin
    entry_t          e;
    int unsigned     n_exp;
    int unsigned     exp_exec;
    dbg_word_t       exp_entry;
    dbg_byte_t       b;
    mem_addr_t       base;
    longint unsigned total;

    total = 2;
    foreach (tests[t]) begin
      total += entry_bytes(tests[t]);
    end
    limit_ns = total * FrameBits * ClksPerBit * ClkPeriodNs * 3;
    exp_exec = 0;

    repeat (2) @(posedge clk);
    rst_i <= 1'b0;

    fork
      begin
        dbg_byte_t got;
        forever begin
          recv_byte(got);
          rx_q.push_back(got);
        end
      end
      forever begin
        @(negedge clk);
        if (exec_valid_o) begin
          exec_count++;
          exec_seen = exec_entry_o;
        end
      end
      begin
        #(limit_ns);
        report_fail("Run timed out before the test table completed");
      end
    join_none

    quiet_window();

    foreach (tests[t]) begin
      e = tests[t];
      base = e.addr[MemAddrWidth-1:0];
      case (e.op)
        OpChal: begin
          send_byte(CodeAck);
          n_exp = 1;
        end
        OpJunk: begin
          send_byte(e.addr[7:0]);
          n_exp = 0;
        end
        OpExec: begin
          send_byte(CmdExec);
          send_field(e.addr);
          n_exp = 1;
          exp_exec++;
          exp_entry = e.addr[31:0];
        end
        default: begin
          send_byte((e.op == OpWrite) ? CmdWrite : CmdRead);
          send_field(e.addr);
          // Top length byte lies above the kept 16 bits
          send_field({8'hc3, 40'h0, 16'(e.len)});
          n_exp = (e.op == OpWrite) ? 2 : e.len + 2;
          if (e.src == SrcLfsr) begin
            for (int i = 0; i < e.len; i++) begin
              rand_byte(b);
              shadow[mem_addr_t'(base + i)] = b;
              send_byte(b);
            end
          end
        end
      endcase

      while (rx_q.size() < n_exp) begin
        @(negedge clk);
      end
      quiet_window();

      check_word("uart_tx_o byte count", dbg_word_t'(rx_q.size()), dbg_word_t'(n_exp));
      if (n_exp > 0) begin
        check_byte("uart_tx_o ack", rx_q[0], CodeAck);
      end
      if (e.src == SrcShadow) begin
        for (int i = 0; i < e.len; i++) begin
          check_byte("uart_tx_o read data", rx_q[i+1], shadow[mem_addr_t'(base + i)]);
        end
      end
      if (e.op == OpWrite || e.op == OpRead) begin
        check_byte("uart_tx_o eot", rx_q[n_exp-1], CodeEot);
      end
      check_word("exec_valid_o pulse count", dbg_word_t'(exec_count), dbg_word_t'(exp_exec));
      if (exp_exec > 0) begin
        check_word("exec_entry_o at pulse", exec_seen, exp_entry);
        check_word("exec_entry_o", exec_entry_o, exp_entry);
      end
      rx_q.delete();
    end

    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: uart_dbg_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_dbg_top (
  input  logic        clk,
  input  logic        rst_i,
  input  logic        uart_rx_i,
  output logic        uart_tx_o,
  output logic        exec_valid_o,
  output logic [31:0] exec_entry_o
);
  import uart_dbg_pkg::*;

  logic      rx_valid;
  dbg_byte_t rx_byte;
  logic      tx_push;
  dbg_byte_t tx_byte;
  logic      tx_credit;

  mem_port_if mem_port ();

  uart_rx i_uart_rx (
    .clk        ( clk       ),
    .rst_i      ( rst_i     ),
    .rx_i       ( uart_rx_i ),
    .rx_valid_o ( rx_valid  ),
    .rx_byte_o  ( rx_byte   )
  );

  uart_dbg_engine i_engine (
    .clk          ( clk          ),
    .rst_i        ( rst_i        ),
    .rx_valid_i   ( rx_valid     ),
    .rx_byte_i    ( rx_byte      ),
    .tx_push_o    ( tx_push      ),
    .tx_byte_o    ( tx_byte      ),
    .tx_credit_i  ( tx_credit    ),
    .mem          ( mem_port     ),
    .exec_valid_o ( exec_valid_o ),
    .exec_entry_o ( exec_entry_o )
  );

  dbg_mem i_mem (
    .clk  ( clk      ),
    .port ( mem_port )
  );

  uart_tx i_uart_tx (
    .clk      ( clk       ),
    .rst_i    ( rst_i     ),
    .push_i   ( tx_push   ),
    .byte_i   ( tx_byte   ),
    .credit_o ( tx_credit ),
    .tx_o     ( uart_tx_o )
  );

endmodule

`default_nettype wire

// File: uart_dbg_engine.sv
`timescale 1ns/1ps
`default_nettype none

module uart_dbg_engine (
  input  logic                    clk,
  input  logic                    rst_i,
  input  logic                    rx_valid_i,
  input  uart_dbg_pkg::dbg_byte_t rx_byte_i,
  output logic                    tx_push_o,
  output uart_dbg_pkg::dbg_byte_t tx_byte_o,
  input  logic                    tx_credit_i,
  mem_port_if.ctrl                mem,
  output logic                    exec_valid_o,
  output uart_dbg_pkg::dbg_word_t exec_entry_o
);
  import uart_dbg_pkg::*;

  typedef enum logic [2:0] {
    StIdle, StAddr, StLen, StAck, StRdReq, StRdPush, StWrData, StEot
  } state_e;

  state_e                   state_q;
  dbg_byte_t                cmd_q;
  logic [FieldIdxWidth-1:0] fld_q;
  credit_t                  credit_q;
  mem_addr_t                addr_q;
  dbg_len_t                 len_q;

  logic has_credit;
  logic fld_last;
  logic last_byte;
  logic mem_access;

  assign has_credit = (credit_q != '0);
  assign fld_last   = (fld_q == FieldIdxWidth'(FieldBytes - 1));
  assign last_byte  = (len_q == dbg_len_t'(1));
  assign mem_access = (state_q == StRdReq && has_credit) ||
                      (state_q == StWrData && rx_valid_i);

  ////////////////////////////////////////////////////////////
  // Outputs to memory and transmitter
  ////////////////////////////////////////////////////////////

  always_comb begin
    mem.req      = mem_access;
    mem.we       = (state_q == StWrData);
    mem.addr     = addr_q;
    mem.wdata    = rx_byte_i;
    tx_push_o    = 1'b0;
    tx_byte_o    = CodeAck;
    exec_valid_o = 1'b0;
    case (state_q)
      StAck: begin
        tx_push_o    = has_credit;
        exec_valid_o = has_credit && (cmd_q == CmdExec);
      end
      // Credit was checked when the read was issued
      StRdPush: begin
        tx_push_o = 1'b1;
        tx_byte_o = mem.rdata;
      end
      StEot: begin
        tx_push_o = has_credit;
        tx_byte_o = CodeEot;
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q  <= StIdle;
      cmd_q    <= '0;
      fld_q    <= '0;
      credit_q <= credit_t'(TxDepth);
    end else begin
      case ({tx_push_o, tx_credit_i})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: ;
      endcase
      case (state_q)
        StIdle: begin
          if (rx_valid_i) begin
            cmd_q <= rx_byte_i;
            fld_q <= '0;
            case (rx_byte_i)
              CodeAck:                    state_q <= StAck;
              CmdRead, CmdWrite, CmdExec: state_q <= StAddr;
              default: ;
            endcase
          end
        end
        StAddr: begin
          if (rx_valid_i) begin
            fld_q <= fld_q + 1'b1;
            if (fld_last) begin
              state_q <= (cmd_q == CmdExec) ? StAck : StLen;
            end
          end
        end
        StLen: begin
          if (rx_valid_i) begin
            fld_q <= fld_q + 1'b1;
            if (fld_last) begin
              state_q <= StAck;
            end
          end
        end
        StAck: begin
          if (has_credit) begin
            case (cmd_q)
              CmdRead:  state_q <= (len_q == '0) ? StEot : StRdReq;
              CmdWrite: state_q <= (len_q == '0) ? StEot : StWrData;
              default:  state_q <= StIdle;
            endcase
          end
        end
        StRdReq: begin
          if (has_credit) begin
            state_q <= StRdPush;
          end
        end
        StRdPush: state_q <= last_byte ? StEot : StRdReq;
        StWrData: begin
          if (rx_valid_i && last_byte) begin
            state_q <= StEot;
          end
        end
        StEot: begin
          if (has_credit) begin
            state_q <= StIdle;
          end
        end
        default: state_q <= StIdle;
      endcase
    end
  end

  // Little-endian field assembly; bytes beyond the kept widths are dropped
  always_ff @(posedge clk) begin
    if (state_q == StAddr && rx_valid_i) begin
      if (cmd_q == CmdExec) begin
        if (fld_q < FieldIdxWidth'($bits(dbg_word_t) / 8)) begin
          exec_entry_o[8*fld_q[1:0] +: 8] <= rx_byte_i;
        end
      end else if (fld_q == '0) begin
        addr_q <= mem_addr_t'(rx_byte_i);
      end
    end
    if (state_q == StLen && rx_valid_i) begin
      if (fld_q < FieldIdxWidth'($bits(dbg_len_t) / 8)) begin
        len_q[8*fld_q[0] +: 8] <= rx_byte_i;
      end
    end
    // Address wraps modulo the memory size
    if (mem_access) begin
      addr_q <= addr_q + 1'b1;
    end
    if (state_q == StRdPush || (state_q == StWrData && rx_valid_i)) begin
      len_q <= len_q - 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: dbg_mem.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_mem (
  input logic       clk,
  mem_port_if.mem   port
);
  import uart_dbg_pkg::*;

  dbg_byte_t mem_q [MemDepth];

  // Writes land on the request edge, reads show up one cycle later
  always_ff @(posedge clk) begin
    if (port.req) begin
      if (port.we) begin
        mem_q[port.addr] <= port.wdata;
      end else begin
        port.rdata <= mem_q[port.addr];
      end
    end
  end

endmodule

`default_nettype wire

// File: uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
  input  logic                    clk,
  input  logic                    rst_i,
  input  logic                    push_i,
  input  uart_dbg_pkg::dbg_byte_t byte_i,
  output logic                    credit_o,
  output logic                    tx_o
);
  import uart_dbg_pkg::*;

  dbg_byte_t              fifo_q [TxDepth];
  logic [TxPtrWidth-1:0]  wr_ptr_q;
  logic [TxPtrWidth-1:0]  rd_ptr_q;
  credit_t                count_q;

  logic                   busy_q;
  logic [BitIdxWidth-1:0] bit_q;
  logic [BitCntWidth-1:0] cnt_q;
  logic [FrameBits-1:0]   frame_q;
  logic                   bit_end;
  logic                   frame_done;
  logic                   start;

  assign bit_end    = busy_q && (cnt_q == BitCntWidth'(ClksPerBit - 1));
  assign frame_done = bit_end && (bit_q == BitIdxWidth'(FrameBits - 1));
  // Next byte starts right as the stop bit ends
  assign start      = (count_q != '0) && (!busy_q || frame_done);
  assign tx_o       = busy_q ? frame_q[0] : 1'b1;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      busy_q   <= 1'b0;
      bit_q    <= '0;
      cnt_q    <= '0;
      credit_o <= 1'b0;
    end else begin
      credit_o <= frame_done;
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (start) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_i, start})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
      if (start) begin
        busy_q <= 1'b1;
        bit_q  <= '0;
        cnt_q  <= '0;
      end else if (frame_done) begin
        busy_q <= 1'b0;
      end else if (bit_end) begin
        cnt_q <= '0;
        bit_q <= bit_q + 1'b1;
      end else if (busy_q) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push_i) begin
      fifo_q[wr_ptr_q] <= byte_i;
    end
    // Stop, data, start; shifted out from bit 0
    if (start) begin
      frame_q <= {1'b1, fifo_q[rd_ptr_q], 1'b0};
    end else if (bit_end) begin
      frame_q <= {1'b1, frame_q[FrameBits-1:1]};
    end
  end

endmodule

`default_nettype wire

// File: uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
  input  logic                    clk,
  input  logic                    rst_i,
  input  logic                    rx_i,
  output logic                    rx_valid_o,
  output uart_dbg_pkg::dbg_byte_t rx_byte_o
);
  import uart_dbg_pkg::*;

  logic [1:0]             sync_q;
  logic                   rx_line;
  logic                   busy_q;
  // 0 is the start bit, FrameBits-1 the stop bit
  logic [BitIdxWidth-1:0] bit_q;
  logic [BitCntWidth-1:0] cnt_q;
  logic                   bit_end;
  dbg_byte_t              shift_q;

  assign rx_line   = sync_q[1];
  assign bit_end   = (cnt_q == BitCntWidth'(ClksPerBit - 1));
  assign rx_byte_o = shift_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      sync_q     <= 2'b11;
      busy_q     <= 1'b0;
      bit_q      <= '0;
      cnt_q      <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      sync_q     <= {sync_q[0], rx_i};
      rx_valid_o <= 1'b0;
      if (!busy_q) begin
        if (!rx_line) begin
          busy_q <= 1'b1;
          bit_q  <= '0;
          cnt_q  <= '0;
        end
      end else if (bit_q == '0) begin
        // Re-check the start bit at its centre
        if (cnt_q == BitCntWidth'(HalfBit - 1)) begin
          cnt_q <= '0;
          if (rx_line) begin
            busy_q <= 1'b0;
          end else begin
            bit_q <= bit_q + 1'b1;
          end
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end else if (bit_end) begin
        cnt_q <= '0;
        bit_q <= bit_q + 1'b1;
        if (bit_q == BitIdxWidth'(FrameBits - 1)) begin
          busy_q     <= 1'b0;
          // Framing error drops the byte
          rx_valid_o <= rx_line;
        end
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk) begin
    if (busy_q && bit_end && bit_q != '0 && bit_q != BitIdxWidth'(FrameBits - 1)) begin
      shift_q <= {rx_line, shift_q[7:1]};
    end
  end

endmodule

`default_nettype wire

// File: mem_port_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_port_if;
  import uart_dbg_pkg::*;

  logic      req;
  logic      we;
  mem_addr_t addr;
  dbg_byte_t wdata;
  // Valid on the cycle after a read request
  dbg_byte_t rdata;

  modport ctrl (
    output req, we, addr, wdata,
    input  rdata
  );

  modport mem (
    input  req, we, addr, wdata,
    output rdata
  );

endinterface

`default_nettype wire

// File: uart_dbg_pkg.sv
`default_nettype none

package uart_dbg_pkg;

  ////////////////////////////////////////////////////////////
  // Serial timing
  ////////////////////////////////////////////////////////////

  localparam int unsigned ClksPerBit  = 16;
  localparam int unsigned HalfBit     = ClksPerBit / 2;
  localparam int unsigned BitCntWidth = $clog2(ClksPerBit);
  // Start, eight data bits, stop
  localparam int unsigned FrameBits   = 10;
  localparam int unsigned BitIdxWidth = $clog2(FrameBits);

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////

  localparam int unsigned FieldBytes    = 8;
  localparam int unsigned FieldIdxWidth = $clog2(FieldBytes);
  localparam int unsigned MemAddrWidth  = 8;
  localparam int unsigned MemDepth      = 2 ** MemAddrWidth;
  localparam int unsigned TxDepth       = 4;
  localparam int unsigned TxPtrWidth    = $clog2(TxDepth);

  typedef logic [7:0]                     dbg_byte_t;
  typedef logic [MemAddrWidth-1:0]        mem_addr_t;
  typedef logic [15:0]                    dbg_len_t;
  typedef logic [31:0]                    dbg_word_t;
  typedef logic [$clog2(TxDepth+1)-1:0]   credit_t;

  ////////////////////////////////////////////////////////////
  // Protocol byte codes
  ////////////////////////////////////////////////////////////

  localparam dbg_byte_t CmdRead  = 8'h11;
  localparam dbg_byte_t CmdWrite = 8'h12;
  localparam dbg_byte_t CmdExec  = 8'h13;
  localparam dbg_byte_t CodeAck  = 8'h06;
  localparam dbg_byte_t CodeEot  = 8'h04;

endpackage

`default_nettype wire
